// ==== sketch_pkg.sv ====
`default_nettype none

package sketch_pkg;

    ////////////////////////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////////////////////////
    typedef logic [63:0] beat_data_t;
    typedef logic [7:0]  beat_strb_t;
    typedef logic [15:0] byte_count_t;  // saturates at 16'hffff
    typedef logic [15:0] flow_id_t;
    typedef logic [31:0] hash_word_t;   // products and sum, mod 2^32

    typedef struct packed {
        byte_count_t byte_count;  // upper half
        flow_id_t    flow_id;     // lower half
    } sketch_record_t;

    typedef struct packed {
        beat_data_t  key;         // first beat of the packet
        byte_count_t byte_count;
    } pkt_summary_t;

    typedef struct packed {
        beat_data_t data;
        beat_strb_t strb;
        logic       last;
    } stream_beat_t;

    // 2-universal hash multipliers, low and high key half
    localparam hash_word_t HASH_A = 32'h9e3779b1;
    localparam hash_word_t HASH_B = 32'h85ebca6b;

    typedef enum logic {
        IDLE,
        IN_PACKET
    } ingress_state_t;

endpackage

`default_nettype wire

// ==== packet_ingress.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_ingress
(
    input  wire                           clk,
    input  wire                           memreset,
    input  wire sketch_pkg::stream_beat_t s_beat,
    input  wire                           s_valid,
    output logic                          s_ready,
    input  wire                           almost_full,
    output sketch_pkg::pkt_summary_t      summary,
    output logic                          summary_valid
);

    sketch_pkg::ingress_state_t state;
    sketch_pkg::beat_data_t     key_q;
    sketch_pkg::byte_count_t    count_q;
    sketch_pkg::byte_count_t    count_base;
    sketch_pkg::byte_count_t    count_next;
    logic [3:0]                 beat_bytes;
    logic [16:0]                count_sum;   // one spare bit for saturation
    logic                       accept;

    assign s_ready = ~almost_full;  // store keeps room for the pipeline
    assign accept  = s_valid & s_ready;

    ////////////////////////////////////////////////////////////
    // byte counting
    ////////////////////////////////////////////////////////////
    assign beat_bytes = 4'($countones(s_beat.strb));

    always_comb
    begin
        // a new packet starts counting from zero
        count_base = (state == sketch_pkg::IDLE) ? '0 : count_q;
        count_sum  = {1'b0, count_base} + 17'(beat_bytes);
        count_next = count_sum[16] ? 16'hffff : count_sum[15:0];
    end

    ////////////////////////////////////////////////////////////
    // packet FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            state         <= sketch_pkg::IDLE;
            summary_valid <= 1'b0;
        end
        else
        begin
            summary_valid <= accept & s_beat.last;  // one-cycle strobe
            if (accept)
            begin
                if (s_beat.last)
                    state <= sketch_pkg::IDLE;
                else
                    state <= sketch_pkg::IN_PACKET;
            end
        end
    end

    // key and count, payload only
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            count_q <= count_next;
            if (state == sketch_pkg::IDLE)
                key_q <= s_beat.data;  // first beat is the flow key
        end
    end

    assign summary.key        = key_q;
    assign summary.byte_count = count_q;

endmodule

`default_nettype wire

// ==== flow_hash.sv ====
`timescale 1ns/1ps
`default_nettype none

module flow_hash
(
    input  wire                           clk,
    input  wire                           memreset,
    input  wire sketch_pkg::pkt_summary_t summary,
    input  wire                           summary_valid,
    output sketch_pkg::sketch_record_t    record_in,
    output logic                          record_in_valid
);

    sketch_pkg::hash_word_t  prod_lo;
    sketch_pkg::hash_word_t  prod_hi;
    sketch_pkg::byte_count_t count_s1;
    logic                    s1_valid;
    sketch_pkg::hash_word_t  hash_sum;

    ////////////////////////////////////////////////////////////
    // stage 1, the two products
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        prod_lo  <= summary.key[31:0]  * sketch_pkg::HASH_A;  // mod 2^32
        prod_hi  <= summary.key[63:32] * sketch_pkg::HASH_B;
        count_s1 <= summary.byte_count;
    end

    ////////////////////////////////////////////////////////////
    // stage 2, sum and fold to 16 bits
    ////////////////////////////////////////////////////////////
    assign hash_sum = prod_lo + prod_hi;

    always_ff @(posedge clk)
    begin
        record_in.byte_count <= count_s1;
        record_in.flow_id    <= hash_sum[31:16] ^ hash_sum[15:0];
    end

    // valid bits, one per stage
    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            s1_valid        <= 1'b0;
            record_in_valid <= 1'b0;
        end
        else
        begin
            s1_valid        <= summary_valid;
            record_in_valid <= s1_valid;
        end
    end

endmodule

`default_nettype wire

// ==== record_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module record_store
#(
    parameter int RECORD_DEPTH   = 16,
    parameter int INFLIGHT_SLOTS = 3
)
(
    input  wire                             clk,
    input  wire                             memreset,
    input  wire sketch_pkg::sketch_record_t record_in,
    input  wire                             record_in_valid,
    output logic                            almost_full,
    output sketch_pkg::sketch_record_t      head_record,
    output logic                            head_valid,
    input  wire                             pop
);

    localparam int PTR_W = (RECORD_DEPTH > 1) ? $clog2(RECORD_DEPTH) : 1;

    localparam logic [PTR_W-1:0] LAST_IDX   = (PTR_W)'(RECORD_DEPTH - 1);
    localparam logic [PTR_W:0]   FULL_LEVEL = (PTR_W + 1)'(RECORD_DEPTH);
    localparam logic [PTR_W:0]   AF_LEVEL   = (PTR_W + 1)'(RECORD_DEPTH - INFLIGHT_SLOTS);

    sketch_pkg::sketch_record_t mem [RECORD_DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [PTR_W:0]             level;   // fill level, 0 to RECORD_DEPTH

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (record_in_valid)
            mem[wr_ptr] <= record_in;
    end

    assign head_record = mem[rd_ptr];
    assign head_valid  = (level != '0);
    assign almost_full = (level >= AF_LEVEL);

    ////////////////////////////////////////////////////////////
    // pointers and level
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            if (record_in_valid)
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;

            case ({record_in_valid, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;  // both or neither
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    // ingress must have stopped early enough for the pipeline to drain
    a_no_write_full: assert property (
        @(posedge clk) disable iff (memreset)
        record_in_valid |-> (level != FULL_LEVEL)
    ) else $error("record_store: write while full");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (memreset)
        pop |-> head_valid
    ) else $error("record_store: pop while empty");

endmodule

`default_nettype wire

// ==== record_egress.sv ====
`timescale 1ns/1ps
`default_nettype none

module record_egress
(
    input  wire                             clk,
    input  wire                             memreset,
    input  wire sketch_pkg::sketch_record_t head_record,
    input  wire                             head_valid,
    output logic                            pop,
    output sketch_pkg::sketch_record_t      m_record,
    output logic                            m_valid,
    input  wire                             m_ready
);

    logic take;

    assign take = m_valid & m_ready;
    // refill when empty or when the current record leaves this cycle
    assign pop  = head_valid & (~m_valid | m_ready);

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (memreset)
            m_valid <= 1'b0;
        else if (pop)
            m_valid <= 1'b1;
        else if (take)
            m_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (pop)
            m_record <= head_record;
    end

    // a stalled record must not change under the consumer
    a_hold_stable: assert property (
        @(posedge clk) disable iff (memreset)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_record))
    ) else $error("record_egress: m_record changed while stalled");

endmodule

`default_nettype wire

// ==== sketch_fifo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sketch_fifo_top
#(
    parameter int RECORD_DEPTH   = 16,
    parameter int INFLIGHT_SLOTS = 3   // summary reg plus two hash stages
)
(
    input  wire                           clk,
    input  wire                           memreset,
    input  wire sketch_pkg::stream_beat_t s_beat,
    input  wire                           s_valid,
    output logic                          s_ready,
    output sketch_pkg::sketch_record_t    m_record,
    output logic                          m_valid,
    input  wire                           m_ready
);

    sketch_pkg::pkt_summary_t   summary;
    logic                       summary_valid;
    sketch_pkg::sketch_record_t record_in;
    logic                       record_in_valid;
    logic                       almost_full;
    sketch_pkg::sketch_record_t head_record;
    logic                       head_valid;
    logic                       pop;

    ////////////////////////////////////////////////////////////
    // ingress -> hash -> store -> egress
    ////////////////////////////////////////////////////////////
    packet_ingress u_packet_ingress (
        .clk           (clk),
        .memreset      (memreset),
        .s_beat        (s_beat),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .almost_full   (almost_full),
        .summary       (summary),
        .summary_valid (summary_valid)
    );

    flow_hash u_flow_hash (
        .clk             (clk),
        .memreset        (memreset),
        .summary         (summary),
        .summary_valid   (summary_valid),
        .record_in       (record_in),
        .record_in_valid (record_in_valid)
    );

    record_store #(
        .RECORD_DEPTH   (RECORD_DEPTH),
        .INFLIGHT_SLOTS (INFLIGHT_SLOTS)
    ) u_record_store (
        .clk             (clk),
        .memreset        (memreset),
        .record_in       (record_in),
        .record_in_valid (record_in_valid),
        .almost_full     (almost_full),
        .head_record     (head_record),
        .head_valid      (head_valid),
        .pop             (pop)
    );

    record_egress u_record_egress (
        .clk         (clk),
        .memreset    (memreset),
        .head_record (head_record),
        .head_valid  (head_valid),
        .pop         (pop),
        .m_record    (m_record),
        .m_valid     (m_valid),
        .m_ready     (m_ready)
    );

endmodule

`default_nettype wire

// ==== sketch_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module sketch_checker
(
    input  wire                             clk,
    input  wire                             memreset,
    input  wire                             s_ready,
    input  wire sketch_pkg::sketch_record_t m_record,
    input  wire                             m_valid,
    input  wire                             m_ready,
    input  wire                             end_of_test,
    output int                              records_seen,
    output int                              expected_total,
    output int                              mismatch_errors,
    output int                              missing_errors,
    output int                              extra_errors,
    output int                              other_errors
);

    localparam int VEC_MAX = 128;

    logic [87:0] vectors [VEC_MAX];
    logic [87:0] expected_q [$];  // tag 2 words in file order
    logic        reset_seen;      // last edge was in reset
    logic        stall_seen;
    logic        end_done;

    initial
    begin
        int i;
        for (i = 0; i < VEC_MAX; i++)
            vectors[i] = '0;
        $readmemh("sketch_vectors.hex", vectors);
        for (i = 0; i < VEC_MAX; i++)
            if (vectors[i][87:84] == 4'h2)
                expected_q.push_back(vectors[i]);
        expected_total = expected_q.size();
    end

    function automatic string test_name(input logic [7:0] num);
        case (num)
            8'd2:    return "single_beat";
            8'd3:    return "multi_beat";
            8'd4:    return "key_compare";
            8'd5:    return "backpressure_burst";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare_record();
        logic [87:0] word;
        if (records_seen >= expected_total)
        begin
            extra_errors++;
            $display("extra record %h came out after all %0d expected records",
                     m_record, expected_total);
        end
        else
        begin
            word = expected_q[records_seen];
            if (m_record !== word[31:0])
            begin
                mismatch_errors++;
                $display("CHECK FAILED %s: expected %h, actual %h",
                         test_name(word[83:76]), word[31:0], m_record);
            end
        end
        records_seen++;
    endtask

    ////////////////////////////////////////////////////////////
    // port watch, sampled on the rising edge
    ////////////////////////////////////////////////////////////
    always @(posedge clk)
    begin
        if (memreset)
        begin
            records_seen    = 0;
            mismatch_errors = 0;
            missing_errors  = 0;
            extra_errors    = 0;
            other_errors    = 0;
            reset_seen      = 1'b1;
            stall_seen      = 1'b0;
            end_done        = 1'b0;
        end
        else
        begin
            if (reset_seen && (m_valid !== 1'b0 || s_ready !== 1'b1))
            begin
                other_errors++;
                $display("after reset m_valid should be low and s_ready high, got %b and %b",
                         m_valid, s_ready);
            end
            reset_seen = 1'b0;
            if (!s_ready)
                stall_seen = 1'b1;
            if (m_valid && m_ready)
                compare_record();
            if (end_of_test && !end_done)
            begin
                if (records_seen < expected_total)
                begin
                    missing_errors = expected_total - records_seen;
                    $display("%0d expected records never came out", missing_errors);
                end
                if (!stall_seen)
                begin
                    other_errors++;
                    $display("s_ready never went low, the full store was not reached");
                end
                end_done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_sketch_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sketch_fifo;

    localparam int VEC_MAX = 128;

    logic                       clk;
    logic                       memreset;
    sketch_pkg::stream_beat_t   s_beat;
    logic                       s_valid;
    logic                       s_ready;
    sketch_pkg::sketch_record_t m_record;
    logic                       m_valid;
    logic                       m_ready;
    logic                       end_of_test;
    logic                       random_ready;  // set by a tag 3 word
    logic [87:0]                vectors [VEC_MAX];
    int                         vec_count;
    int                         timeout_limit = 200;
    int                         cycle_count = 0;
    int                         drain_cycles;
    int                         records_seen;
    int                         expected_total;
    int                         mismatch_errors;
    int                         missing_errors;
    int                         extra_errors;
    int                         other_errors;

    sketch_fifo_top u_sketch_fifo_top (
        .clk      (clk),
        .memreset (memreset),
        .s_beat   (s_beat),
        .s_valid  (s_valid),
        .s_ready  (s_ready),
        .m_record (m_record),
        .m_valid  (m_valid),
        .m_ready  (m_ready)
    );

    sketch_checker u_sketch_checker (
        .clk             (clk),
        .memreset        (memreset),
        .s_ready         (s_ready),
        .m_record        (m_record),
        .m_valid         (m_valid),
        .m_ready         (m_ready),
        .end_of_test     (end_of_test),
        .records_seen    (records_seen),
        .expected_total  (expected_total),
        .mismatch_errors (mismatch_errors),
        .missing_errors  (missing_errors),
        .extra_errors    (extra_errors),
        .other_errors    (other_errors)
    );

    ////////////////////////////////////////////////////////////
    // clock and m_ready
    ////////////////////////////////////////////////////////////
    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    initial
    begin
        logic [31:0] lcg_state;
        lcg_state = 32'h26d4839b;
        m_ready   = 1'b1;
        forever
        begin
            @(negedge clk);
            if (random_ready)
            begin
                lcg_state = lcg_next(lcg_state);
                m_ready   = (lcg_state[31:29] == 3'b000);  // about one in eight
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    // starts on a falling edge and returns on the one after the transfer
    task automatic send_beat(input logic [87:0] word);
        s_beat.data = word[63:0];
        s_beat.strb = word[71:64];
        s_beat.last = word[72];
        s_valid     = 1'b1;
        while (!s_ready)
            @(negedge clk);
        @(negedge clk);
    endtask

    task automatic print_error_counts();
        $display("errors: mismatch=%0d missing=%0d extra=%0d other=%0d", mismatch_errors,
                 missing_errors, extra_errors, other_errors);
    endtask

    initial
    begin
        int i;
        memreset     = 1'b1;
        s_beat       = '0;
        s_valid      = 1'b0;
        end_of_test  = 1'b0;
        random_ready = 1'b0;
        for (i = 0; i < VEC_MAX; i++)
            vectors[i] = '0;
        $readmemh("sketch_vectors.hex", vectors);
        vec_count = 0;
        while (vec_count < VEC_MAX && vectors[vec_count][87:84] != 4'h0)
            vec_count++;
        timeout_limit = 40 * vec_count + 200;

        repeat (10) @(posedge clk);
        @(negedge clk);
        memreset = 1'b0;

        for (i = 0; i < vec_count; i++)
        begin
            case (vectors[i][87:84])
                4'h1:    send_beat(vectors[i]);
                4'h3:    random_ready = 1'b1;
                default: ;  // expected records belong to the checker
            endcase
        end
        s_valid = 1'b0;

        // bounded wait so that lost records still reach the checker's report
        drain_cycles = 0;
        while (records_seen < expected_total && drain_cycles < 40 * expected_total)
        begin
            @(negedge clk);
            drain_cycles++;
        end
        repeat (20) @(negedge clk);  // give stray records time to show
        end_of_test = 1'b1;
        repeat (2) @(negedge clk);

        print_error_counts();
        if (mismatch_errors + missing_errors + extra_errors + other_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit)
        begin
            $display("timeout after %0d cycles, only %0d of %0d records came out",
                     cycle_count, records_seen, expected_total);
            print_error_counts();
            $display("=== FAIL ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sketch_vectors.hex ====
// tag(1) test(2) last(1) strb(2) data_hi(8) data_lo(8)
// tag 1 input beat, tag 2 expected record in data_lo, tag 3 random m_ready
// test 2, single beat packets
1_02_1_ff_00000000_00000100 2_02_0_00_00000000_00088679
1_02_1_0f_00000000_00010000 2_02_0_00_00000000_000479b1
// test 3, three beats, partial last strobe
1_03_0_ff_00000100_00000100
1_03_0_ff_deadbeef_01234567
1_03_1_07_cafef00d_89abcdef 2_03_0_00_00000000_00133f44
// test 4, same key twice then different keys
1_04_1_01_00000001_00000001 2_04_0_00_00000000_0001603f
1_04_0_ff_00000001_00000001
1_04_1_03_55aa55aa_0f0f0f0f 2_04_0_00_00000000_000a603f
1_04_1_ff_00000000_00000001 2_04_0_00_00000000_0008e786
1_04_1_80_00000001_00000000 2_04_0_00_00000000_00014f80
1_04_1_3c_00000000_00000002 2_04_0_00_00000000_0004cf0c
3_05_0_00_00000000_00000000
// test 5, burst of 24 packets under random m_ready
1_05_1_ff_00000000_00000000 2_05_0_00_00000000_00080000
1_05_1_01_00000000_00000001 2_05_0_00_00000000_0001e786
1_05_1_03_00000001_00000000 2_05_0_00_00000000_00024f80
1_05_1_07_00000001_00000001 2_05_0_00_00000000_0003603f
1_05_1_0f_00000000_00000002 2_05_0_00_00000000_0004cf0c
1_05_1_1f_00000000_00000100 2_05_0_00_00000000_00058679
1_05_1_3f_00000100_00000100 2_05_0_00_00000000_00063f44
1_05_1_7f_00000000_00010000 2_05_0_00_00000000_000779b1
1_05_1_ff_00000000_01000000 2_05_0_00_00000000_0008b100
1_05_1_01_00010000_00000000 2_05_0_00_00000000_0001ca6b
1_05_1_c0_00000000_00000001 2_05_0_00_00000000_0002e786
1_05_1_e0_00000001_00000000 2_05_0_00_00000000_00034f80
1_05_1_f0_00000001_00000001 2_05_0_00_00000000_0004603f
1_05_1_f8_00000000_00000002 2_05_0_00_00000000_0005cf0c
1_05_1_fc_00000000_00000100 2_05_0_00_00000000_00068679
1_05_1_fe_00000100_00000100 2_05_0_00_00000000_00073f44
1_05_1_55_00000000_00010000 2_05_0_00_00000000_000479b1
1_05_1_aa_00000000_01000000 2_05_0_00_00000000_0004b100
1_05_1_0f_00010000_00000000 2_05_0_00_00000000_0004ca6b
1_05_1_33_00000000_00000000 2_05_0_00_00000000_00040000
1_05_1_11_00000000_00000001 2_05_0_00_00000000_0002e786
1_05_1_ff_00000001_00000000 2_05_0_00_00000000_00084f80
1_05_1_18_00000001_00000001 2_05_0_00_00000000_0002603f
1_05_1_81_00000000_00000002 2_05_0_00_00000000_0002cf0c

// ==== sources.f ====
sketch_pkg.sv
packet_ingress.sv
flow_hash.sv
record_store.sv
record_egress.sv
sketch_fifo_top.sv
sketch_checker.sv
tb_sketch_fifo.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_sketch_fifo -f sources.f
./obj_dir/Vtb_sketch_fifo | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0
